// ==== dfdCfgPkg.sv ====
// ******************************
// APB widths, register map offsets and
// CTRL field positions for the debugger
// ******************************

package dfdCfgPkg;

  // ******************************
  // APB bus
  // ******************************
  localparam int ApbAddrWidth = 12;
  localparam int ApbDataWidth = 32;

  // ******************************
  // Register map, byte offsets
  // ******************************
  localparam logic [ApbAddrWidth-1:0] RegCtrl       = 12'h000;
  localparam logic [ApbAddrWidth-1:0] RegStartMask  = 12'h004;
  localparam logic [ApbAddrWidth-1:0] RegStartValue = 12'h008;
  localparam logic [ApbAddrWidth-1:0] RegStopMask   = 12'h00C;
  localparam logic [ApbAddrWidth-1:0] RegStopValue  = 12'h010;
  // Read only
  localparam logic [ApbAddrWidth-1:0] RegDropCount  = 12'h014;
  localparam logic [ApbAddrWidth-1:0] RegTime       = 12'h018;

  // CTRL fields
  localparam int CtrlEnBit    = 0;
  localparam int CtrlSelLsb   = 1;
  localparam int CtrlSelWidth = 2;

endpackage

// ==== dfdTracePkg.sv ====
// ******************************
// Debug bus and timestamp widths, output
// queue depth, packet kinds and the
// packet word union
// ******************************

package dfdTracePkg;

  localparam int HalfWidth   = 16;
  localparam int NumHalves   = 8;
  localparam int DbgBusWidth = 32;
  localparam int SelWidth    = 2;

  localparam int SeqWidth  = 7;
  localparam int TimeWidth = 39;
  localparam int PktWidth  = 40;

  // Entries in the trace output queue
  localparam int QueueDepth = 2;

  typedef enum logic {
    KindSample = 1'b0,
    KindTime   = 1'b1
  } pktKind_e;

  // Sample packet layout
  typedef struct packed {
    pktKind_e               kind;
    logic [SeqWidth-1:0]    seq;
    logic [DbgBusWidth-1:0] bus;
  } samplePkt_s;

  // Timestamp packet layout
  typedef struct packed {
    pktKind_e             kind;
    logic [TimeWidth-1:0] ts;
  } timePkt_s;

  // Kind sits in the top bit of both views
  typedef union packed {
    samplePkt_s smp;
    timePkt_s   stamp;
  } tracePkt_u;

endpackage

// ==== dfdRegs.sv ====
// ******************************
// APB register block
// Offset decode, CTRL and match registers,
// read data mux and slave error
// ******************************

`timescale 1ns/1ps

module dfdRegs (
  input  logic                                  i_clk,
  input  logic                                  i_arstN,
  input  logic                                  i_psel,
  input  logic                                  i_penable,
  input  logic                                  i_pwrite,
  input  logic [dfdCfgPkg::ApbAddrWidth-1:0]    i_paddr,
  input  logic [dfdCfgPkg::ApbDataWidth-1:0]    i_pwdata,
  input  logic [dfdCfgPkg::ApbDataWidth-1:0]    i_dropCount,
  input  logic [dfdTracePkg::TimeWidth-1:0]     i_time,
  output logic                                  o_pready,
  output logic [dfdCfgPkg::ApbDataWidth-1:0]    o_prdata,
  output logic                                  o_pslverr,
  output logic                                  o_enable,
  output logic [dfdTracePkg::SelWidth-1:0]      o_muxSel,
  output logic [dfdTracePkg::DbgBusWidth-1:0]   o_startMask,
  output logic [dfdTracePkg::DbgBusWidth-1:0]   o_startValue,
  output logic [dfdTracePkg::DbgBusWidth-1:0]   o_stopMask,
  output logic [dfdTracePkg::DbgBusWidth-1:0]   o_stopValue
);

  import dfdCfgPkg::*;

  logic                    access;
  logic [ApbAddrWidth-1:0] regOff;
  logic                    mapped;
  logic                    readOnly;
  logic                    wrEn;

  // Zero wait states, so every access phase completes
  assign access   = i_psel & i_penable;
  assign o_pready = access;

  // Word offsets only
  assign regOff = {i_paddr[ApbAddrWidth-1:2], 2'b00};

  always_comb begin
    o_prdata = '0;
    mapped   = 1'b1;
    readOnly = 1'b0;
    case (regOff)
      RegCtrl: begin
        o_prdata[CtrlEnBit]                = o_enable;
        o_prdata[CtrlSelLsb+:CtrlSelWidth] = o_muxSel;
      end
      RegStartMask:  o_prdata = o_startMask;
      RegStartValue: o_prdata = o_startValue;
      RegStopMask:   o_prdata = o_stopMask;
      RegStopValue:  o_prdata = o_stopValue;
      RegDropCount: begin
        o_prdata = i_dropCount;
        readOnly = 1'b1;
      end
      RegTime: begin
        // Low word of the timestamp
        o_prdata = i_time[ApbDataWidth-1:0];
        readOnly = 1'b1;
      end
      default: mapped = 1'b0;
    endcase
  end

  assign o_pslverr = access & (~mapped | (i_pwrite & readOnly));
  assign wrEn      = access & i_pwrite & ~o_pslverr;

  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      o_enable     <= 1'b0;
      o_muxSel     <= '0;
      o_startMask  <= '0;
      o_startValue <= '0;
      o_stopMask   <= '0;
      o_stopValue  <= '0;
    end else if (wrEn) begin
      case (regOff)
        RegCtrl: begin
          o_enable <= i_pwdata[CtrlEnBit];
          o_muxSel <= i_pwdata[CtrlSelLsb+:CtrlSelWidth];
        end
        RegStartMask:  o_startMask  <= i_pwdata;
        RegStartValue: o_startValue <= i_pwdata;
        RegStopMask:   o_stopMask   <= i_pwdata;
        RegStopValue:  o_stopValue  <= i_pwdata;
        default: ;
      endcase
    end
  end

  aSlvErrInAccess: assert property (@(posedge i_clk) disable iff (!i_arstN)
    o_pslverr |-> o_pready);

endmodule

// ==== dfdAnalyzer.sv ====
// ******************************
// Logic analyzer
// Debug mux, timestamp counter and
// masked start/stop trace control
// ******************************

`timescale 1ns/1ps

module dfdAnalyzer (
  input  logic                                i_clk,
  input  logic                                i_arstN,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw0,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw1,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw2,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw3,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw4,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw5,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw6,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw7,
  input  logic                                i_timeTick,
  input  logic                                i_enable,
  input  logic [dfdTracePkg::SelWidth-1:0]    i_muxSel,
  input  logic [dfdTracePkg::DbgBusWidth-1:0] i_startMask,
  input  logic [dfdTracePkg::DbgBusWidth-1:0] i_startValue,
  input  logic [dfdTracePkg::DbgBusWidth-1:0] i_stopMask,
  input  logic [dfdTracePkg::DbgBusWidth-1:0] i_stopValue,
  output logic [dfdTracePkg::DbgBusWidth-1:0] o_dbgBus,
  output logic [dfdTracePkg::TimeWidth-1:0]   o_time,
  output logic                                o_start,
  output logic                                o_tracing,
  output logic                                o_change
);

  import dfdTracePkg::*;

  logic [HalfWidth-1:0]   halves [NumHalves];
  logic [DbgBusWidth-1:0] prevBus;
  logic                   startMatch;
  logic                   stopMatch;

  assign halves[0] = i_hw0;
  assign halves[1] = i_hw1;
  assign halves[2] = i_hw2;
  assign halves[3] = i_hw3;
  assign halves[4] = i_hw4;
  assign halves[5] = i_hw5;
  assign halves[6] = i_hw6;
  assign halves[7] = i_hw7;

  // ******************************
  // Debug mux, pair 2s+1 : 2s
  // ******************************
  always_ff @(posedge i_clk) begin
    o_dbgBus <= {halves[{i_muxSel, 1'b1}], halves[{i_muxSel, 1'b0}]};
    prevBus  <= o_dbgBus;
  end

  assign o_change = o_tracing & (o_dbgBus != prevBus);

  // Masked compares against the registered bus
  assign startMatch = i_enable & ~o_tracing &
                      (((o_dbgBus ^ i_startValue) & i_startMask) == '0);
  assign stopMatch  = o_tracing & (((o_dbgBus ^ i_stopValue) & i_stopMask) == '0);

  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      o_tracing <= 1'b0;
      o_start   <= 1'b0;
      o_time    <= '0;
    end else begin
      o_start <= startMatch;
      if (!i_enable) begin
        o_tracing <= 1'b0;
      end else if (startMatch) begin
        o_tracing <= 1'b1;
      end else if (stopMatch) begin
        o_tracing <= 1'b0;
      end
      if (i_timeTick) begin
        o_time <= o_time + 1'b1;
      end
    end
  end

  aStartOnlyFromIdle: assert property (@(posedge i_clk) disable iff (!i_arstN)
    o_start |-> !$past(o_tracing));

endmodule

// ==== dfdTracePacker.sv ====
// ******************************
// Trace packetizer
// Packet build, two-entry output queue,
// sequence numbering and drop counter
// ******************************

`timescale 1ns/1ps

module dfdTracePacker (
  input  logic                                i_clk,
  input  logic                                i_arstN,
  input  logic [dfdTracePkg::DbgBusWidth-1:0] i_dbgBus,
  input  logic [dfdTracePkg::TimeWidth-1:0]   i_time,
  input  logic                                i_start,
  input  logic                                i_change,
  input  logic                                i_pktReady,
  output logic                                o_pktValid,
  output logic [dfdTracePkg::PktWidth-1:0]    o_pktData,
  output logic [dfdCfgPkg::ApbDataWidth-1:0]  o_dropCount
);

  import dfdTracePkg::*;

  tracePkt_u                          pktNext;
  logic [PktWidth-1:0]                queue [QueueDepth];
  logic [$clog2(QueueDepth)-1:0]      wrPtr;
  logic [$clog2(QueueDepth)-1:0]      rdPtr;
  logic [$clog2(QueueDepth+1)-1:0]    count;
  logic [SeqWidth-1:0]                seqNum;
  logic                               push;
  logic                               pop;
  logic                               accept;
  logic                               drop;

  // Start wins over a change in the same cycle
  always_comb begin
    if (i_start) begin
      pktNext.stamp.kind = KindTime;
      pktNext.stamp.ts   = i_time;
    end else begin
      pktNext.smp.kind = KindSample;
      pktNext.smp.seq  = seqNum;
      pktNext.smp.bus  = i_dbgBus;
    end
  end

  assign push   = i_start | i_change;
  assign pop    = o_pktValid & i_pktReady;
  assign accept = push & (count != QueueDepth);
  assign drop   = push & (count == QueueDepth);

  assign o_pktValid = (count != '0);
  assign o_pktData  = queue[rdPtr];

  always_ff @(posedge i_clk) begin
    if (accept) begin
      queue[wrPtr] <= pktNext;
    end
  end

  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      wrPtr       <= '0;
      rdPtr       <= '0;
      count       <= '0;
      seqNum      <= '0;
      o_dropCount <= '0;
    end else begin
      if (accept) wrPtr <= wrPtr + 1'b1;
      if (pop) rdPtr <= rdPtr + 1'b1;
      case ({accept, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      // Dropped samples still consume a sequence number
      if (i_start) begin
        seqNum <= '0;
      end else if (i_change) begin
        seqNum <= seqNum + 1'b1;
      end
      if (drop && (o_dropCount != '1)) begin
        o_dropCount <= o_dropCount + 1'b1;
      end
    end
  end

  aHoldUnderStall: assert property (@(posedge i_clk) disable iff (!i_arstN)
    (o_pktValid && !i_pktReady) |=> (o_pktValid && $stable(o_pktData)));

endmodule

// ==== dfdTop.sv ====
// ******************************
// Debugger top level
// Register block, analyzer and packetizer
// ******************************

`timescale 1ns/1ps

module dfdTop (
  input  logic                                i_clk,
  input  logic                                i_arstN,
  input  logic                                i_psel,
  input  logic                                i_penable,
  input  logic                                i_pwrite,
  input  logic [dfdCfgPkg::ApbAddrWidth-1:0]  i_paddr,
  input  logic [dfdCfgPkg::ApbDataWidth-1:0]  i_pwdata,
  output logic                                o_pready,
  output logic [dfdCfgPkg::ApbDataWidth-1:0]  o_prdata,
  output logic                                o_pslverr,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw0,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw1,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw2,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw3,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw4,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw5,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw6,
  input  logic [dfdTracePkg::HalfWidth-1:0]   i_hw7,
  input  logic                                i_timeTick,
  input  logic                                i_pktReady,
  output logic                                o_pktValid,
  output logic [dfdTracePkg::PktWidth-1:0]    o_pktData
);

  import dfdCfgPkg::*;
  import dfdTracePkg::*;

  logic                    enable;
  logic [SelWidth-1:0]     muxSel;
  logic [DbgBusWidth-1:0]  startMask;
  logic [DbgBusWidth-1:0]  startValue;
  logic [DbgBusWidth-1:0]  stopMask;
  logic [DbgBusWidth-1:0]  stopValue;
  logic [DbgBusWidth-1:0]  dbgBus;
  logic [TimeWidth-1:0]    timeStamp;
  logic                    start;
  logic                    change;
  logic [ApbDataWidth-1:0] dropCount;

  dfdRegs dfdRegs_i (
    .i_clk        (i_clk),
    .i_arstN      (i_arstN),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_paddr      (i_paddr),
    .i_pwdata     (i_pwdata),
    .i_dropCount  (dropCount),
    .i_time       (timeStamp),
    .o_pready     (o_pready),
    .o_prdata     (o_prdata),
    .o_pslverr    (o_pslverr),
    .o_enable     (enable),
    .o_muxSel     (muxSel),
    .o_startMask  (startMask),
    .o_startValue (startValue),
    .o_stopMask   (stopMask),
    .o_stopValue  (stopValue)
  );

  // Tracing level is only observed inside the analyzer
  dfdAnalyzer dfdAnalyzer_i (
    .i_clk        (i_clk),
    .i_arstN      (i_arstN),
    .i_hw0        (i_hw0),
    .i_hw1        (i_hw1),
    .i_hw2        (i_hw2),
    .i_hw3        (i_hw3),
    .i_hw4        (i_hw4),
    .i_hw5        (i_hw5),
    .i_hw6        (i_hw6),
    .i_hw7        (i_hw7),
    .i_timeTick   (i_timeTick),
    .i_enable     (enable),
    .i_muxSel     (muxSel),
    .i_startMask  (startMask),
    .i_startValue (startValue),
    .i_stopMask   (stopMask),
    .i_stopValue  (stopValue),
    .o_dbgBus     (dbgBus),
    .o_time       (timeStamp),
    .o_start      (start),
    .o_tracing    (),
    .o_change     (change)
  );

  dfdTracePacker dfdTracePacker_i (
    .i_clk        (i_clk),
    .i_arstN      (i_arstN),
    .i_dbgBus     (dbgBus),
    .i_time       (timeStamp),
    .i_start      (start),
    .i_change     (change),
    .i_pktReady   (i_pktReady),
    .o_pktValid   (o_pktValid),
    .o_pktData    (o_pktData),
    .o_dropCount  (dropCount)
  );

endmodule

// ==== dfdTbTests.svh ====
// ******************************
// Directed tests for the debugger
// Register access, mux select, start/stop,
// timestamp and back-pressure
// ******************************

localparam int NumSamples  = 5;
localparam int NumTicks    = 10;
localparam int NumStalled  = 6;
localparam int QuietCycles = 20;

// Upper halfword patterns seen on select 0
localparam logic [HalfWidth-1:0] StartHalf = 16'h1234;
localparam logic [HalfWidth-1:0] StopHalf  = 16'h0F0F;

function automatic logic [HalfWidth-1:0] freshHalf(input logic [HalfWidth-1:0] old);
  logic [HalfWidth-1:0] v;
  v = randHalf();
  if (v == old) begin
    v = ~old;
  end
  return v;
endfunction

// Select 0 with start and stop keyed on the upper half only
task automatic armTrace();
  regWrite(RegCtrl, 32'h0);
  hwVal[1] = '0;
  hwVal[0] = randHalf();
  regWrite(RegStartMask, 32'hFFFF_0000);
  regWrite(RegStartValue, {StartHalf, 16'h0000});
  regWrite(RegStopMask, 32'hFFFF_0000);
  regWrite(RegStopValue, {StopHalf, 16'h0000});
  rxQ.delete();
  regWrite(RegCtrl, 32'h1);
endtask

task automatic startTrace();
  stepDrive();
  hwVal[1] = StartHalf;
  waitPackets(1);
  checkEq(rxQ[0][PktWidth-1], KindTime, "first packet kind");
endtask

task automatic testRegAccess();
  logic [ApbAddrWidth-1:0] addrs [5];
  logic [ApbDataWidth-1:0] vals [5];
  logic [ApbDataWidth-1:0] rd;
  bit                      err;
  beginTest();
  // Idle state out of reset
  checkEq(pready, 1'b0, "ready before first access");
  checkEq(pslverr, 1'b0, "slave error after reset");
  checkEq(pktValid, 1'b0, "packet valid after reset");
  regRead(RegDropCount, rd);
  checkEq(rd, 0, "drop count after reset");
  addrs = '{RegStartMask, RegStartValue, RegStopMask, RegStopValue, RegCtrl};
  foreach (vals[i]) vals[i] = {randHalf(), randHalf()};
  // Random select field with enable left clear
  vals[4] = vals[4] & 32'h6;
  foreach (addrs[i]) regWrite(addrs[i], vals[i]);
  foreach (addrs[i]) begin
    regRead(addrs[i], rd);
    checkEq(rd, vals[i], "register readback");
  end
  apbAccess(1'b0, 12'h01C, '0, rd, err);
  checkEq(err, 1'b1, "slave error on unmapped read");
  apbAccess(1'b1, RegTime, 32'h5, rd, err);
  checkEq(err, 1'b1, "slave error on time write");
  endTest("register access");
endtask

task automatic testMuxSelect();
  logic [DbgBusWidth-1:0] pair;
  logic [PktWidth-1:0]    pkt;
  beginTest();
  for (int s = 0; s < 4; s++) begin
    regWrite(RegCtrl, 32'h0);
    foreach (hwVal[i]) hwVal[i] = randHalf();
    pair = {hwVal[2*s+1], hwVal[2*s]};
    regWrite(RegStartMask, '1);
    regWrite(RegStartValue, pair);
    // Upper half stays put so the inverse never matches
    regWrite(RegStopMask, '1);
    regWrite(RegStopValue, ~pair);
    rxQ.delete();
    regWrite(RegCtrl, {29'b0, 2'(s), 1'b1});
    waitPackets(1);
    checkEq(rxQ[0][PktWidth-1], KindTime, "time packet kind");
    stepDrive();
    hwVal[2*s] = freshHalf(hwVal[2*s]);
    pair = {hwVal[2*s+1], hwVal[2*s]};
    waitPackets(2);
    pkt = rxQ[1];
    checkEq(pkt[PktWidth-1], KindSample, "sample packet kind");
    checkEq(pkt[PktWidth-2 -: SeqWidth], 0, "sample sequence number");
    checkEq(pkt[DbgBusWidth-1:0], pair, "selected halfword pair");
  end
  regWrite(RegCtrl, 32'h0);
  endTest("mux selection");
endtask

task automatic testStartStop();
  logic [DbgBusWidth-1:0] expBus [NumSamples];
  logic [PktWidth-1:0]    pkt;
  beginTest();
  armTrace();
  startTrace();
  for (int k = 0; k < NumSamples; k++) begin
    stepDrive();
    hwVal[0] = freshHalf(hwVal[0]);
    // Last change also shows the stop pattern
    if (k == NumSamples - 1) begin
      hwVal[1] = StopHalf;
    end
    expBus[k] = {hwVal[1], hwVal[0]};
  end
  waitPackets(NumSamples + 1);
  for (int k = 0; k < NumSamples; k++) begin
    pkt = rxQ[k+1];
    checkEq(pkt[PktWidth-1], KindSample, "sample packet kind");
    checkEq(pkt[PktWidth-2 -: SeqWidth], k, "sample sequence number");
    checkEq(pkt[DbgBusWidth-1:0], expBus[k], "sample bus value");
  end
  for (int k = 0; k < 3; k++) begin
    stepDrive();
    hwVal[0] = freshHalf(hwVal[0]);
  end
  quietWindow(QuietCycles);
  checkEq(rxQ.size(), NumSamples + 1, "packet count after stop");
  regWrite(RegCtrl, 32'h0);
  endTest("start and stop");
endtask

task automatic testTimestamp();
  logic [ApbDataWidth-1:0] rd;
  logic [PktWidth-1:0]     pkt;
  beginTest();
  armTrace();
  repeat (NumTicks) begin
    stepDrive();
    timeTick = 1'b1;
    stepDrive();
    timeTick = 1'b0;
  end
  startTrace();
  pkt = rxQ[0];
  checkTrue(pkt[TimeWidth-1:0] >= NumTicks, "time packet stamp below tick count");
  regRead(RegTime, rd);
  checkTrue(rd >= NumTicks, "time register below tick count");
  regWrite(RegCtrl, 32'h0);
  endTest("timestamp");
endtask

task automatic testBackPressure();
  logic [ApbDataWidth-1:0] dropBefore;
  logic [ApbDataWidth-1:0] dropAfter;
  logic [PktWidth-1:0]     pkt;
  int                      samples;
  int                      lastSeq;
  beginTest();
  armTrace();
  startTrace();
  regRead(RegDropCount, dropBefore);
  pktReady = 1'b0;
  for (int k = 0; k < NumStalled; k++) begin
    stepDrive();
    hwVal[0] = freshHalf(hwVal[0]);
  end
  quietWindow(4);
  stepDrive();
  pktReady = 1'b1;
  waitDrain();
  regRead(RegDropCount, dropAfter);
  samples = rxQ.size() - 1;
  checkEq(samples + (dropAfter - dropBefore), NumStalled, "received plus dropped samples");
  checkTrue(dropAfter - dropBefore >= NumStalled - QueueDepth, "drop count too low");
  lastSeq = -1;
  for (int k = 1; k < rxQ.size(); k++) begin
    pkt = rxQ[k];
    checkTrue(int'(pkt[PktWidth-2 -: SeqWidth]) > lastSeq, "sequence numbers not increasing");
    lastSeq = int'(pkt[PktWidth-2 -: SeqWidth]);
  end
  regWrite(RegCtrl, 32'h0);
  endTest("back-pressure");
endtask

// ==== dfdTb.sv ====
// ******************************
// Testbench top for the debugger
// Clock, reset, DUT, APB and packet
// helpers, test sequence and summary
// ******************************

`timescale 1ns/1ps

module dfdTb;

  import dfdCfgPkg::*;
  import dfdTracePkg::*;

  localparam int          ClkPeriod     = 100;
  localparam int          DriveDelay    = 5;
  localparam int          ResetCycles   = 16;
  localparam int          TimeoutCycles = 200;
  localparam logic [31:0] Seed          = 32'h4864;

  logic                    clk;
  logic                    arstN;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [ApbAddrWidth-1:0] paddr;
  logic [ApbDataWidth-1:0] pwdata;
  logic                    pready;
  logic [ApbDataWidth-1:0] prdata;
  logic                    pslverr;
  logic [HalfWidth-1:0]    hwVal [NumHalves];
  logic                    timeTick;
  logic                    pktReady;
  logic                    pktValid;
  logic [PktWidth-1:0]     pktData;

  logic [31:0]             lcgState;
  logic [PktWidth-1:0]     rxQ [$];
  int                      checkCount;
  int                      errCount;
  int                      testCount;
  int                      testErrStart;

  dfdTop dfdTop_i (
    .i_clk      (clk),
    .i_arstN    (arstN),
    .i_psel     (psel),
    .i_penable  (penable),
    .i_pwrite   (pwrite),
    .i_paddr    (paddr),
    .i_pwdata   (pwdata),
    .o_pready   (pready),
    .o_prdata   (prdata),
    .o_pslverr  (pslverr),
    .i_hw0      (hwVal[0]),
    .i_hw1      (hwVal[1]),
    .i_hw2      (hwVal[2]),
    .i_hw3      (hwVal[3]),
    .i_hw4      (hwVal[4]),
    .i_hw5      (hwVal[5]),
    .i_hw6      (hwVal[6]),
    .i_hw7      (hwVal[7]),
    .i_timeTick (timeTick),
    .i_pktReady (pktReady),
    .o_pktValid (pktValid),
    .o_pktData  (pktData)
  );

  initial clk = 1'b0;
  always #(ClkPeriod/2) clk = ~clk;

  // Words accepted by the sink at mid-cycle
  always @(negedge clk) begin
    if (arstN && pktValid && pktReady) begin
      rxQ.push_back(pktData);
    end
  end

  // ******************************
  // Helpers
  // ******************************
  function automatic logic [HalfWidth-1:0] randHalf();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[31:16];
  endfunction

  task automatic stepDrive();
    @(posedge clk);
    #DriveDelay;
  endtask

  task automatic abortRun(input string what);
    $display("Timeout at %0t: no %s within %0d cycles", $time, what, TimeoutCycles);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
    checkCount++;
    assert (got === exp) else begin
      $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errCount++;
    end
  endtask

  task automatic checkTrue(input bit cond, input string what);
    checkCount++;
    assert (cond) else begin
      $display("[FAIL] %0t: %s", $time, what);
      errCount++;
    end
  endtask

  task automatic beginTest();
    testErrStart = errCount;
    testCount++;
  endtask

  task automatic endTest(input string name);
    if (errCount == testErrStart) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errCount - testErrStart);
    end
  endtask

  task automatic apbAccess(input bit write, input logic [ApbAddrWidth-1:0] addr,
                           input logic [ApbDataWidth-1:0] wdata,
                           output logic [ApbDataWidth-1:0] rdata, output bit err);
    int waited;
    stepDrive();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    stepDrive();
    penable = 1'b1;
    waited  = 0;
    @(negedge clk);
    while (!pready && waited < TimeoutCycles) begin
      @(negedge clk);
      waited++;
    end
    if (!pready) begin
      abortRun("APB ready");
    end
    // Zero wait states
    checkEq(waited, 0, "APB wait states");
    rdata = prdata;
    err   = pslverr;
    stepDrive();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic regWrite(input logic [ApbAddrWidth-1:0] addr,
                          input logic [ApbDataWidth-1:0] data);
    logic [ApbDataWidth-1:0] unused;
    bit                      err;
    apbAccess(1'b1, addr, data, unused, err);
    checkEq(err, 1'b0, "slave error on write");
  endtask

  task automatic regRead(input logic [ApbAddrWidth-1:0] addr,
                         output logic [ApbDataWidth-1:0] data);
    bit err;
    apbAccess(1'b0, addr, '0, data, err);
    checkEq(err, 1'b0, "slave error on read");
  endtask

  task automatic waitPackets(input int n);
    int waited;
    waited = 0;
    while (rxQ.size() < n && waited < TimeoutCycles) begin
      @(posedge clk);
      waited++;
    end
    if (rxQ.size() < n) begin
      abortRun("trace packet");
    end
  endtask

  task automatic waitDrain();
    int waited;
    waited = 0;
    @(negedge clk);
    while (pktValid && waited < TimeoutCycles) begin
      @(negedge clk);
      waited++;
    end
    if (pktValid) begin
      abortRun("empty output queue");
    end
  endtask

  task automatic quietWindow(input int cycles);
    repeat (cycles) @(posedge clk);
  endtask

  `include "dfdTbTests.svh"

  initial begin
    lcgState   = Seed;
    checkCount = 0;
    errCount   = 0;
    testCount  = 0;
    arstN      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    timeTick   = 1'b0;
    pktReady   = 1'b1;
    foreach (hwVal[i]) hwVal[i] = '0;
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    arstN = 1'b1;

    testRegAccess();
    testMuxSelect();
    testStartStop();
    testTimestamp();
    testBackPressure();

    quietWindow(4);
    $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+.
dfdCfgPkg.sv
dfdTracePkg.sv
dfdRegs.sv
dfdAnalyzer.sv
dfdTracePacker.sv
dfdTop.sv
dfdTb.sv

// ==== Bender.yml ====
package:
  name: dfd

sources:
  - files:
      - dfdCfgPkg.sv
      - dfdTracePkg.sv
      - dfdRegs.sv
      - dfdAnalyzer.sv
      - dfdTracePacker.sv
      - dfdTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - dfdTb.sv
